// File: design/merge_params.svh
// --------------------------------------------------
// sizes shared by the merge engine and its testbench
// --------------------------------------------------
`ifndef MERGE_PARAMS_SVH
`define MERGE_PARAMS_SVH

// fields carried by one data packet
`define MERGE_NUM_FIELDS 4

// field and result width
`define MERGE_FIELD_W 32

// memory byte offset width
`define MERGE_ADDR_W 16

// word offsets owned by one engine
`define MERGE_SEQ_WIDTH 16

// depth of config and result FIFOs
`define MERGE_FIFO_DEPTH 8

`endif

// File: design/merge_pkg.sv
// --------------------------------------------------
// merge engine types: response command, reduction
// operation, configuration and result records
// --------------------------------------------------
`include "merge_params.svh"

package merge_pkg;

// enough bits to count every field of a packet
localparam int RESULT_COUNT_W = $clog2(`MERGE_NUM_FIELDS + 1);

// memory response command
typedef enum logic [1:0] {
    CMD_INVALID     = 2'd0,
    CMD_MEM_READ    = 2'd1,
    CMD_MEM_WRITE   = 2'd2,
    CMD_MEM_PROGRAM = 2'd3
} merge_cmd_e;

// reduction applied to the masked fields
// min and max compare unsigned, sum wraps
typedef enum logic [1:0] {
    MERGE_SUM = 2'd0,
    MERGE_MIN = 2'd1,
    MERGE_MAX = 2'd2,
    MERGE_OR  = 2'd3
} merge_op_e;

// one assembled configuration
typedef struct packed {
    logic [`MERGE_NUM_FIELDS-1:0] merge_mask;
    merge_op_e                    merge_op;
} merge_config_t;

// result queue entry
typedef struct packed {
    logic [`MERGE_FIELD_W-1:0] data;
    logic [RESULT_COUNT_W-1:0] count;
} merge_result_t;

endpackage : merge_pkg

// File: design/merge_sync_fifo.sv
// --------------------------------------------------
// synchronous show-ahead FIFO, any payload type
// --------------------------------------------------
`timescale 1ns/1ns

module merge_sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic     ap_clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full,
    output logic     almost_full
);

localparam int               PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int               CNT_W = $clog2(DEPTH + 1);
localparam logic [PTR_W-1:0] LAST  = PTR_W'(DEPTH - 1);

payload_t         mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             do_push;
logic             do_pop;

// requests against a full or empty queue are dropped
assign do_push = push & ~full;
assign do_pop  = pop & ~empty;

always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push) begin
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
        end
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge ap_clk) begin
    if (do_push) begin
        mem[wr_ptr] <= push_data;
    end
end

// head entry always visible
assign pop_data    = mem[rd_ptr];
assign empty       = (count == '0);
assign full        = (count == CNT_W'(DEPTH));
assign almost_full = (count >= CNT_W'(DEPTH - 1));

endmodule : merge_sync_fifo

// File: design/merge_config_decode.sv
// --------------------------------------------------
// program response filter and merge configuration
// assembly for one engine's sequence window
// --------------------------------------------------
`timescale 1ns/1ns
`include "merge_params.svh"

module merge_config_decode #(
    parameter int unsigned SEQ_MIN = 0
) (
    input  logic                      ap_clk,
    input  logic                      rst_n,
    input  logic                      mem_valid,
    input  merge_pkg::merge_cmd_e     mem_cmd,
    input  logic [`MERGE_ADDR_W-1:0]  mem_offset,
    input  logic [3:0]                mem_shift,
    input  logic [`MERGE_FIELD_W-1:0] mem_data,
    output logic                      cfg_push,
    output merge_pkg::merge_config_t  cfg_word
);

import merge_pkg::*;

localparam int unsigned SEQ_END = SEQ_MIN + `MERGE_SEQ_WIDTH;

// --------------------------------------------------
// registered reset and input
// --------------------------------------------------
logic                         rst_q;
logic                         mem_valid_q;
merge_cmd_e                   mem_cmd_q;
logic [`MERGE_ADDR_W-1:0]     mem_offset_q;
logic [3:0]                   mem_shift_q;
logic [`MERGE_NUM_FIELDS-1:0] mem_low_q;

// --------------------------------------------------
// filter and sequence state
// --------------------------------------------------
logic [`MERGE_ADDR_W-1:0]     word_index;
logic                         in_window;
logic                         word_accept;
logic [1:0]                   seq_q;
logic [`MERGE_NUM_FIELDS-1:0] mask_q;

always_ff @(posedge ap_clk) begin
    rst_q <= rst_n;
end

always_ff @(posedge ap_clk) begin
    if (!rst_q) begin
        mem_valid_q <= 1'b0;
    end else begin
        mem_valid_q <= mem_valid;
    end
end

// only the low data bits ever reach a configuration
always_ff @(posedge ap_clk) begin
    mem_cmd_q    <= mem_cmd;
    mem_offset_q <= mem_offset;
    mem_shift_q  <= mem_shift;
    mem_low_q    <= mem_data[`MERGE_NUM_FIELDS-1:0];
end

// byte offset to word index
assign word_index  = mem_offset_q >> mem_shift_q;
assign in_window   = (word_index >= SEQ_MIN) && (word_index < SEQ_END);
assign word_accept = mem_valid_q && (mem_cmd_q == CMD_MEM_PROGRAM) && in_window;

// one-hot sequence: bit 0 waits for the mask word, bit 1 for the op word
always_ff @(posedge ap_clk) begin
    if (!rst_q) begin
        seq_q    <= 2'b01;
        cfg_push <= 1'b0;
    end else begin
        cfg_push <= 1'b0;
        if (word_accept) begin
            if (seq_q[0] && (word_index == SEQ_MIN)) begin
                seq_q <= 2'b10;
            end else if (seq_q[1]) begin
                seq_q    <= 2'b01;
                cfg_push <= 1'b1;
            end
        end
    end
end

// mask and op capture
always_ff @(posedge ap_clk) begin
    if (word_accept && seq_q[0] && (word_index == SEQ_MIN)) begin
        mask_q <= mem_low_q;
    end
    if (word_accept && seq_q[1]) begin
        cfg_word.merge_mask <= mask_q;
        cfg_word.merge_op   <= merge_op_e'(mem_low_q[$bits(merge_op_e)-1:0]);
    end
end

endmodule : merge_config_decode

// File: design/merge_field_execute.sv
// --------------------------------------------------
// active configuration and masked field reduction
// --------------------------------------------------
`timescale 1ns/1ns
`include "merge_params.svh"

module merge_field_execute (
    input  logic                                                ap_clk,
    input  logic                                                rst_n,
    input  logic                                                cfg_empty,
    input  merge_pkg::merge_config_t                            cfg_word,
    input  logic                                                data_valid,
    input  logic [`MERGE_NUM_FIELDS-1:0][`MERGE_FIELD_W-1:0]    data_fields,
    input  logic                                                res_almost_full,
    output logic                                                cfg_pop,
    output logic                                                data_ready,
    output logic                                                res_push,
    output merge_pkg::merge_result_t                            res_word
);

import merge_pkg::*;

logic          rst_q;
merge_config_t active_cfg;
logic          cfg_valid;
logic          cfg_ready_q;
logic          data_accept;

// --------------------------------------------------
// reduction helpers
// --------------------------------------------------
function automatic logic [`MERGE_FIELD_W-1:0] reduce_fields(
    input merge_config_t                                cfg,
    input logic [`MERGE_NUM_FIELDS-1:0][`MERGE_FIELD_W-1:0] fields
);
    logic [`MERGE_FIELD_W-1:0] acc;
    logic                      seen;
    acc  = '0;
    seen = 1'b0;
    for (int i = 0; i < `MERGE_NUM_FIELDS; i++) begin
        if (cfg.merge_mask[i]) begin
            if (!seen) begin
                // first selected field seeds the accumulator
                acc  = fields[i];
                seen = 1'b1;
            end else begin
                case (cfg.merge_op)
                    MERGE_SUM: acc = acc + fields[i];
                    MERGE_MIN: acc = (fields[i] < acc) ? fields[i] : acc;
                    MERGE_MAX: acc = (fields[i] > acc) ? fields[i] : acc;
                    default:   acc = acc | fields[i];
                endcase
            end
        end
    end
    return acc;
endfunction

function automatic logic [RESULT_COUNT_W-1:0] count_mask(
    input logic [`MERGE_NUM_FIELDS-1:0] mask
);
    logic [RESULT_COUNT_W-1:0] n;
    n = '0;
    for (int i = 0; i < `MERGE_NUM_FIELDS; i++) begin
        n = n + RESULT_COUNT_W'(mask[i]);
    end
    return n;
endfunction

always_ff @(posedge ap_clk) begin
    rst_q <= rst_n;
end

// any pending configuration replaces the active one
assign cfg_pop = ~cfg_empty;

// packets wait one cycle after a load, and never with a queued config
// or with fewer than two free result slots
assign data_ready  = cfg_ready_q & cfg_empty & ~res_almost_full;
assign data_accept = data_valid & data_ready;

always_ff @(posedge ap_clk) begin
    if (!rst_q) begin
        cfg_valid   <= 1'b0;
        cfg_ready_q <= 1'b0;
        res_push    <= 1'b0;
    end else begin
        if (cfg_pop) begin
            cfg_valid <= 1'b1;
        end
        cfg_ready_q <= cfg_valid & cfg_empty;
        res_push    <= data_accept;
    end
end

always_ff @(posedge ap_clk) begin
    if (cfg_pop) begin
        active_cfg <= cfg_word;
    end
    if (data_accept) begin
        res_word.data  <= reduce_fields(active_cfg, data_fields);
        res_word.count <= count_mask(active_cfg.merge_mask);
    end
end

endmodule : merge_field_execute

// File: design/merge_engine_top.sv
// --------------------------------------------------
// merge engine: decode, config FIFO, execute and
// result FIFO
// --------------------------------------------------
`timescale 1ns/1ns
`include "merge_params.svh"

module merge_engine_top #(
    parameter int unsigned SEQ_MIN = 0
) (
    input  logic                                             ap_clk,
    input  logic                                             rst_n,
    input  logic                                             mem_valid,
    input  merge_pkg::merge_cmd_e                            mem_cmd,
    input  logic [`MERGE_ADDR_W-1:0]                         mem_offset,
    input  logic [3:0]                                       mem_shift,
    input  logic [`MERGE_FIELD_W-1:0]                        mem_data,
    input  logic                                             data_valid,
    input  logic [`MERGE_NUM_FIELDS-1:0][`MERGE_FIELD_W-1:0] data_fields,
    output logic                                             data_ready,
    output logic                                             result_valid,
    output logic [`MERGE_FIELD_W-1:0]                        result_data,
    output logic [merge_pkg::RESULT_COUNT_W-1:0]             result_count,
    input  logic                                             result_ready
);

import merge_pkg::*;

logic          cfg_push;
merge_config_t cfg_in;
logic          cfg_pop;
merge_config_t cfg_head;
logic          cfg_empty;
logic          res_push;
merge_result_t res_in;
logic          res_almost_full;
merge_result_t res_head;
logic          res_empty;

merge_config_decode #(
    .SEQ_MIN(SEQ_MIN)
) u_decode (
    .ap_clk    (ap_clk),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_cmd   (mem_cmd),
    .mem_offset(mem_offset),
    .mem_shift (mem_shift),
    .mem_data  (mem_data),
    .cfg_push  (cfg_push),
    .cfg_word  (cfg_in)
);

// pending configurations
merge_sync_fifo #(
    .payload_t(merge_config_t),
    .DEPTH    (`MERGE_FIFO_DEPTH)
) u_cfg_fifo (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .push       (cfg_push),
    .push_data  (cfg_in),
    .pop        (cfg_pop),
    .pop_data   (cfg_head),
    .empty      (cfg_empty),
    .full       (),
    .almost_full()
);

merge_field_execute u_execute (
    .ap_clk         (ap_clk),
    .rst_n          (rst_n),
    .cfg_empty      (cfg_empty),
    .cfg_word       (cfg_head),
    .data_valid     (data_valid),
    .data_fields    (data_fields),
    .res_almost_full(res_almost_full),
    .cfg_pop        (cfg_pop),
    .data_ready     (data_ready),
    .res_push       (res_push),
    .res_word       (res_in)
);

// results waiting for the consumer
merge_sync_fifo #(
    .payload_t(merge_result_t),
    .DEPTH    (`MERGE_FIFO_DEPTH)
) u_res_fifo (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .push       (res_push),
    .push_data  (res_in),
    .pop        (result_valid & result_ready),
    .pop_data   (res_head),
    .empty      (res_empty),
    .full       (),
    .almost_full(res_almost_full)
);

assign result_valid = ~res_empty;
assign result_data  = res_head.data;
assign result_count = res_head.count;

endmodule : merge_engine_top

// File: testbench/merge_engine_tb.sv
// --------------------------------------------------
// merge engine testbench: vector file driver, result
// scoreboard and random packets against a reference
// --------------------------------------------------
`timescale 1ns/1ns
`include "merge_params.svh"

module merge_engine_tb;

import merge_pkg::*;

localparam int FW         = `MERGE_FIELD_W;
localparam int CW         = RESULT_COUNT_W;
localparam int WAIT_LIMIT = 200;

typedef logic [`MERGE_NUM_FIELDS-1:0][FW-1:0] fields_t;

logic                     ap_clk;
logic                     rst_n;
logic                     mem_valid;
merge_cmd_e               mem_cmd;
logic [`MERGE_ADDR_W-1:0] mem_offset;
logic [3:0]               mem_shift;
logic [FW-1:0]            mem_data;
logic                     data_valid;
fields_t                  data_fields;
logic                     data_ready;
logic                     result_valid;
logic [FW-1:0]            result_data;
logic [CW-1:0]            result_count;
logic                     result_ready;

// expected results in acceptance order
logic [FW-1:0] exp_data_q[$];
logic [CW-1:0] exp_count_q[$];
int            num_checks;
int            num_errors;
int            blocked_cycles;
int            stall_left;
logic          rand_stall;
logic          timed_out;
logic [31:0]   field_state;
logic [31:0]   stall_state;
int            fd;

merge_engine_top #(
    .SEQ_MIN(4)
) UUT (
    .ap_clk      (ap_clk),
    .rst_n       (rst_n),
    .mem_valid   (mem_valid),
    .mem_cmd     (mem_cmd),
    .mem_offset  (mem_offset),
    .mem_shift   (mem_shift),
    .mem_data    (mem_data),
    .data_valid  (data_valid),
    .data_fields (data_fields),
    .data_ready  (data_ready),
    .result_valid(result_valid),
    .result_data (result_data),
    .result_count(result_count),
    .result_ready(result_ready)
);

always #50 ap_clk = ~ap_clk;

// --------------------------------------------------
// helpers
// --------------------------------------------------
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic line_ok(input int got, input int want);
    if (got != want) begin
        $display("vector line has %0d values where %0d were expected", got, want);
        num_errors++;
        return 1'b0;
    end
    return 1'b1;
endfunction

task automatic check_data(input logic [FW-1:0] got, input logic [FW-1:0] want);
    num_checks++;
    if (got !== want) begin
        $display("FAIL result_data got %h expected %h", got, want);
        num_errors++;
    end
endtask

task automatic check_count(input logic [CW-1:0] got, input logic [CW-1:0] want);
    num_checks++;
    if (got !== want) begin
        $display("FAIL result_count got %h expected %h", got, want);
        num_errors++;
    end
endtask

// op over the masked fields, empty mask gives zero
task automatic reduce_reference(input logic [`MERGE_NUM_FIELDS-1:0] mask,
                                input merge_op_e op, input fields_t f,
                                output logic [FW-1:0] res, output logic [CW-1:0] cnt);
    cnt = '0;
    res = (op == MERGE_MIN) ? '1 : '0;
    for (int i = 0; i < `MERGE_NUM_FIELDS; i++) begin
        if (mask[i]) begin
            cnt = cnt + CW'(1);
            case (op)
                MERGE_SUM: res = res + f[i];
                MERGE_MIN: res = (f[i] < res) ? f[i] : res;
                MERGE_MAX: res = (f[i] > res) ? f[i] : res;
                default:   res = res | f[i];
            endcase
        end
    end
    if (cnt == '0) begin
        res = '0;
    end
endtask

task automatic send_word(input int cmd, input int offset, input int shift, input int data);
    mem_cmd    = merge_cmd_e'(cmd[1:0]);
    mem_offset = offset[`MERGE_ADDR_W-1:0];
    mem_shift  = shift[3:0];
    mem_data   = data;
    mem_valid  = 1'b1;
    @(negedge ap_clk);
    mem_valid  = 1'b0;
endtask

// data_ready seen high here means the transfer happens at the next rising edge
task automatic send_packet(input fields_t f, input logic [FW-1:0] want_data,
                           input logic [CW-1:0] want_count);
    int waited;
    waited      = 0;
    data_fields = f;
    data_valid  = 1'b1;
    while (!data_ready && waited < WAIT_LIMIT) begin
        @(negedge ap_clk);
        waited++;
    end
    if (!data_ready) begin
        $display("timed out waiting for data_ready");
        num_errors++;
        timed_out = 1'b1;
    end else begin
        blocked_cycles += waited;
        exp_data_q.push_back(want_data);
        exp_count_q.push_back(want_count);
        @(negedge ap_clk);
    end
    data_valid = 1'b0;
endtask

task automatic quiet_check(input int n);
    data_fields = '0;
    data_valid  = 1'b1;
    for (int i = 0; i < n; i++) begin
        num_checks++;
        if (data_ready || result_valid) begin
            $display("data_ready or result_valid high before any configuration");
            num_errors++;
        end
        @(negedge ap_clk);
    end
    data_valid = 1'b0;
endtask

task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < WAIT_LIMIT) begin
        @(negedge ap_clk);
        waited++;
    end
    if (exp_data_q.size() != 0) begin
        $display("timed out with %0d results still outstanding", exp_data_q.size());
        num_errors++;
        timed_out = 1'b1;
    end
endtask

// consumer controls change on the rising edge, read on the falling edge
task automatic hold_consumer(input int n, input logic random_mode);
    @(posedge ap_clk);
    stall_left = n;
    rand_stall = random_mode;
    @(negedge ap_clk);
endtask

task automatic next_kind(output logic [7:0] kind, output logic eof);
    int   c;
    logic found;
    kind  = 8'h00;
    eof   = 1'b0;
    found = 1'b0;
    while (!found && !eof) begin
        c = $fgetc(fd);
        if (c < 0) begin
            eof = 1'b1;
        end else if (c == 35) begin
            // hash comment runs to end of line
            while (c >= 0 && c != 10) begin
                c = $fgetc(fd);
            end
        end else if (c > 32) begin
            kind  = c[7:0];
            found = 1'b1;
        end
    end
endtask

// --------------------------------------------------
// result consumer and scoreboard
// --------------------------------------------------
always @(negedge ap_clk) begin : consume_results
    logic [FW-1:0] want_data;
    logic [CW-1:0] want_count;
    if (rst_n) begin
        if (stall_left > 0) begin
            result_ready = 1'b0;
            stall_left--;
        end else if (rand_stall) begin
            stall_state  = xorshift32(stall_state);
            result_ready = (stall_state[1:0] != 2'b00);
        end else begin
            result_ready = 1'b1;
        end
        // head leaves at the next rising edge
        if (result_valid && result_ready) begin
            if (exp_data_q.size() == 0) begin
                $display("result arrived with no packet outstanding");
                num_errors++;
            end else begin
                want_data  = exp_data_q.pop_front();
                want_count = exp_count_q.pop_front();
                check_data(result_data, want_data);
                check_count(result_count, want_count);
            end
        end
    end
end

// --------------------------------------------------
// vector driver
// --------------------------------------------------
initial begin : run_vectors
    logic [7:0]    kind;
    logic          eof;
    logic          stop_run;
    int            rd;
    int            a;
    int            b;
    int            c;
    int            d;
    int            e;
    int            f;
    fields_t       fields;
    logic [FW-1:0] want_data;
    logic [CW-1:0] want_count;
    int            test_num;
    int            test_checks;
    int            test_errors;
    ap_clk         = 1'b0;
    rst_n          = 1'b0;
    mem_valid      = 1'b0;
    mem_cmd        = CMD_INVALID;
    mem_offset     = '0;
    mem_shift      = '0;
    mem_data       = '0;
    data_valid     = 1'b0;
    data_fields    = '0;
    result_ready   = 1'b1;
    num_checks     = 0;
    num_errors     = 0;
    blocked_cycles = 0;
    stall_left     = 0;
    rand_stall     = 1'b0;
    timed_out      = 1'b0;
    field_state    = 32'h828d2c4a;
    stall_state    = 32'h828d2c4a;
    fields         = '0;
    test_num       = 0;
    test_checks    = 0;
    test_errors    = 0;
    stop_run       = 1'b0;
    fd = $fopen("testbench/merge_vectors.txt", "r");
    if (fd == 0) begin
        $display("could not open the vector file");
        num_errors++;
        stop_run = 1'b1;
    end
    repeat (2) @(posedge ap_clk);
    @(negedge ap_clk);
    rst_n = 1'b1;

    while (!stop_run && !timed_out) begin
        next_kind(kind, eof);
        if (eof) begin
            stop_run = 1'b1;
        end else begin
            case (kind)
                "Q": begin
                    rd       = $fscanf(fd, "%h", a);
                    stop_run = !line_ok(rd, 1);
                    if (!stop_run) quiet_check(a);
                end
                "P": begin
                    rd       = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    stop_run = !line_ok(rd, 4);
                    if (!stop_run) send_word(a, b, c, d);
                end
                "I": begin
                    rd       = $fscanf(fd, "%h", a);
                    stop_run = !line_ok(rd, 1);
                    if (!stop_run) repeat (a) @(negedge ap_clk);
                end
                "D": begin
                    rd       = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
                    stop_run = !line_ok(rd, 6);
                    if (!stop_run) begin
                        fields[0] = a;
                        fields[1] = b;
                        fields[2] = c;
                        fields[3] = d;
                        send_packet(fields, e, f[CW-1:0]);
                    end
                end
                "S": begin
                    rd       = $fscanf(fd, "%h", a);
                    stop_run = !line_ok(rd, 1);
                    if (!stop_run) hold_consumer(a, 1'b0);
                end
                "R": begin
                    rd       = $fscanf(fd, "%h %h %h", a, b, c);
                    stop_run = !line_ok(rd, 3);
                    if (!stop_run) begin
                        hold_consumer(0, 1'b1);
                        for (int i = 0; i < a && !timed_out; i++) begin
                            for (int j = 0; j < `MERGE_NUM_FIELDS; j++) begin
                                field_state = xorshift32(field_state);
                                fields[j]   = field_state;
                            end
                            reduce_reference(b[`MERGE_NUM_FIELDS-1:0], merge_op_e'(c[1:0]),
                                             fields, want_data, want_count);
                            send_packet(fields, want_data, want_count);
                        end
                    end
                end
                "B": begin
                    num_checks++;
                    if (blocked_cycles == 0) begin
                        $display("data_ready never dropped while results were held back");
                        num_errors++;
                    end
                end
                "T": begin
                    drain_results();
                    hold_consumer(0, 1'b0);
                    test_num++;
                    $display("test %0d: %0d checks, %0d errors", test_num,
                             num_checks - test_checks, num_errors - test_errors);
                    test_checks    = num_checks;
                    test_errors    = num_errors;
                    blocked_cycles = 0;
                end
                default: begin
                    $display("unknown vector line kind %c", kind);
                    num_errors++;
                    stop_run = 1'b1;
                end
            endcase
        end
    end

    if (fd != 0) begin
        $fclose(fd);
    end
    if (exp_data_q.size() != 0) begin
        $display("%0d results never arrived", exp_data_q.size());
        num_errors++;
    end
    $display("%0d tests, %0d checks, %0d errors", test_num, num_checks, num_errors);
    if (num_errors == 0 && !timed_out) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule : merge_engine_tb

// File: testbench/merge_vectors.txt
# Q n: idle n cycles with data_valid high, no ready or valid allowed | P cmd offset shift data
# I n | D f0 f1 f2 f3 data count | S n stall | R n mask op random | B back-pressure seen | T end
Q 6
T
P 3 0004 0 F
P 3 0005 0 0
I 8
D 1 2 3 4 A 4
D FFFFFFFF 1 10 20 30 4
P 3 0004 0 5
P 3 0005 0 1
I 8
D 50 3 20 1 20 2
D 7 0 80000000 0 7 2
P 3 0004 0 E
P 3 0005 0 2
I 8
D FFFFFFFF 10 300 20 300 3
D 0 80000001 7FFFFFFF 5 80000001 3
P 3 0004 0 B
P 3 0005 0 3
I 8
D 1 2 F0 8 B 3
D 100 1000 FFFF 10000 11100 3
T
P 1 0004 0 F
P 2 0005 0 0
P 0 0004 0 1
P 3 0003 0 1
P 3 0014 0 2
P 3 0006 0 2
I 8
D 1 2 F0 8 B 3
P 3 0004 0 F
P 3 0100 0 2
P 1 0005 0 3
P 3 0005 0 1
I 8
D 9 4 6 5 4 4
T
P 3 000C 2 F
P 3 0010 2 0
P 3 0014 2 2
I 8
D 5 6 7 8 0 0
P 3 0023 3 3
P 3 002F 3 0
I 8
D 10 20 40 80 30 2
T
P 3 0004 0 F
P 3 0005 0 0
I 8
S 1E
D 1 1 1 1 4 4
D 2 2 2 2 8 4
D 3 3 3 3 C 4
D 4 4 4 4 10 4
D 5 5 5 5 14 4
D 6 6 6 6 18 4
D 7 7 7 7 1C 4
D 8 8 8 8 20 4
D 9 9 9 9 24 4
D A A A A 28 4
B
T
P 3 0004 0 D
P 3 0005 0 2
I 8
R 40 D 2
P 3 0004 0 7
P 3 0005 0 0
I 8
R 20 7 0
T

// File: list.f
+incdir+design
design/merge_pkg.sv
design/merge_sync_fifo.sv
design/merge_config_decode.sv
design/merge_field_execute.sv
design/merge_engine_top.sv
testbench/merge_engine_tb.sv

// File: Makefile
# Verilator build and run for the merge engine testbench

VERILATOR  ?= verilator
TOP        ?= merge_engine_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?=
PASS_MSG   ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
